//--- rv_core.f
source/rv_pkg.sv
source/pc_stage.sv
source/decode_stage.sv
source/reg_file.sv
source/exec_stage.sv
source/mem_wb_stage.sv
source/rv_core.sv
tb/rv_core_sva.sv
tb/rv_core_tb.sv

//--- source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage import rv_pkg::*; (
  input  word_t      inst,
  output reg_addr_t  rs1_addr,
  output reg_addr_t  rs2_addr,
  output reg_addr_t  rd_addr,
  output word_t      imm,
  output a_sel_e     a_sel,
  output wb_sel_e    wb_sel,
  output logic [2:0] funct3,
  output logic       reg_we,
  output logic       is_load,
  output logic       is_store,
  output logic       jump_taken,
  output logic       is_jalr,
  output logic       halt
);

  opcode_e opcode;
  word_t   imm_i;
  word_t   imm_s;
  word_t   imm_j;
  word_t   imm_u;

  assign opcode = opcode_e'(inst[6:0]);

  // lui reads x0 so the adder passes the immediate straight through
  assign rs1_addr = (opcode == lui) ? 5'd0 : inst[19:15];
  assign rs2_addr = inst[24:20];
  assign rd_addr  = inst[11:7];
  assign funct3   = inst[14:12];

  // immediate formats, all sign extended from bit 31
  assign imm_i = {{20{inst[31]}}, inst[31:20]};
  assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
  assign imm_j = {{12{inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_u = {inst[31:12], 12'h000};

  always_comb begin
    // defaults describe a no-op
    imm        = imm_i;
    a_sel      = a_sel_rs1;
    wb_sel     = wb_sel_sum;
    reg_we     = 1'b0;
    is_load    = 1'b0;
    is_store   = 1'b0;
    jump_taken = 1'b0;
    is_jalr    = 1'b0;
    halt       = 1'b0;
    case (opcode)
      op_imm: begin
        reg_we = 1'b1;           // addi only
      end
      lui: begin
        imm    = imm_u;
        reg_we = 1'b1;
      end
      auipc: begin
        imm    = imm_u;
        a_sel  = a_sel_pc;
        reg_we = 1'b1;
      end
      jal: begin
        imm        = imm_j;
        a_sel      = a_sel_pc;
        wb_sel     = wb_sel_pc4; // link
        reg_we     = 1'b1;
        jump_taken = 1'b1;
      end
      jalr: begin
        wb_sel     = wb_sel_pc4;
        reg_we     = 1'b1;
        jump_taken = 1'b1;
        is_jalr    = 1'b1;
      end
      load: begin
        wb_sel  = wb_sel_load;
        reg_we  = 1'b1;
        is_load = 1'b1;
      end
      store: begin
        imm      = imm_s;
        is_store = 1'b1;
      end
      system: begin
        halt = 1'b1;             // ebreak
      end
      default: begin
      end
    endcase
  end

endmodule

//--- source/exec_stage.sv
`timescale 1ns/1ps

module exec_stage import rv_pkg::*; (
  input  word_t  pc,
  input  word_t  rs1_data,
  input  word_t  imm,
  input  a_sel_e a_sel,
  input  logic   is_jalr,
  output word_t  sum,
  output word_t  jump_target
);

  word_t op_a;

  // one adder covers addi, lui, auipc, addresses and jump targets
  always_comb begin
    case (a_sel)
      a_sel_pc: op_a = pc;
      default:  op_a = rs1_data;
    endcase
  end

  assign sum = op_a + imm;

  // jalr drops bit 0 of its target
  always_comb begin
    if (is_jalr) begin
      jump_target = {sum[xlen-1:1], 1'b0};
    end else begin
      jump_target = sum;
    end
  end

endmodule

//--- source/mem_wb_stage.sv
`timescale 1ns/1ps

module mem_wb_stage import rv_pkg::*; (
  input  word_t      pc,
  input  word_t      sum,
  input  word_t      rs2_data,
  input  logic [2:0] funct3,
  input  logic       is_load,
  input  logic       is_store,
  input  wb_sel_e    wb_sel,
  input  word_t      mem_rdata,
  output word_t      mem_addr,
  output logic       mem_ren,
  output logic       mem_wen,
  output word_t      mem_wdata,
  output wmask_t     mem_wmask,
  output word_t      rd_data
);

  logic [1:0] offset;
  logic [4:0] bit_shift;
  word_t      lane;
  word_t      load_data;

  assign offset    = sum[1:0];
  assign bit_shift = {offset, 3'b000};   // byte offset in bits

  // word aligned address, lane chosen by offset
  assign mem_addr = {sum[xlen-1:2], 2'b00};
  assign mem_ren  = is_load;
  assign mem_wen  = is_store;

  // store data moves up into its byte lane
  assign mem_wdata = rs2_data << bit_shift;

  always_comb begin
    mem_wmask = 4'b0000;
    if (is_store) begin
      case (funct3)
        f3_b: mem_wmask = 4'b0001 << offset;
        f3_h: begin
          if (!offset[0]) begin
            mem_wmask = 4'b0011 << offset;
          end
        end
        f3_w: begin
          if (offset == 2'd0) begin
            mem_wmask = 4'b1111;
          end
        end
        default: mem_wmask = 4'b0000;
      endcase
    end
  end

  // selected lane lands in the low bits
  assign lane = mem_rdata >> bit_shift;

  always_comb begin
    case (funct3)
      f3_b:    load_data = {{24{lane[7]}}, lane[7:0]};
      f3_h:    load_data = {{16{lane[15]}}, lane[15:0]};
      f3_bu:   load_data = {24'h000000, lane[7:0]};
      f3_hu:   load_data = {16'h0000, lane[15:0]};
      f3_w:    load_data = lane;
      default: load_data = lane;
    endcase
  end

  // writeback source
  always_comb begin
    case (wb_sel)
      wb_sel_pc4:  rd_data = pc + 32'd4;
      wb_sel_load: rd_data = load_data;
      default:     rd_data = sum;
    endcase
  end

endmodule

//--- source/pc_stage.sv
`timescale 1ns/1ps

module pc_stage import rv_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  halt,
  input  logic  jump_taken,
  input  word_t jump_target,
  output word_t pc
);

  word_t pc_q;
  word_t pc_next;

  // sequential next pc unless a jump or a halt says otherwise
  always_comb begin
    if (jump_taken) begin
      pc_next = jump_target;
    end else if (halt) begin
      pc_next = pc_q;            // ebreak parks the core here
    end else begin
      pc_next = pc_q + 32'd4;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= reset_pc;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc = pc_q;

endmodule

//--- source/reg_file.sv
`timescale 1ns/1ps

module reg_file import rv_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      we,
  input  reg_addr_t waddr,
  input  word_t     wdata,
  input  reg_addr_t raddr1,
  input  reg_addr_t raddr2,
  output word_t     rdata1,
  output word_t     rdata2
);

  word_t regs [32];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && (waddr != 5'd0)) begin
      regs[waddr] <= wdata;      // x0 never written
    end
  end

  // combinational reads, x0 hardwired
  always_comb begin
    if (raddr1 == 5'd0) begin
      rdata1 = '0;
    end else begin
      rdata1 = regs[raddr1];
    end
  end

  always_comb begin
    if (raddr2 == 5'd0) begin
      rdata2 = '0;
    end else begin
      rdata2 = regs[raddr2];
    end
  end

endmodule

//--- source/rv_core.sv
`timescale 1ns/1ps

module rv_core import rv_pkg::*; (
  input  logic   clk,
  input  logic   rst_n,
  input  word_t  inst,
  input  word_t  mem_rdata,
  output word_t  pc,
  output word_t  mem_addr,
  output logic   mem_ren,
  output logic   mem_wen,
  output word_t  mem_wdata,
  output wmask_t mem_wmask,
  output logic   halt
);

  reg_addr_t  rs1_addr;
  reg_addr_t  rs2_addr;
  reg_addr_t  rd_addr;
  word_t      imm;
  a_sel_e     a_sel;
  wb_sel_e    wb_sel;
  logic [2:0] funct3;
  logic       reg_we;
  logic       is_load;
  logic       is_store;
  logic       jump_taken;
  logic       is_jalr;
  word_t      rs1_data;
  word_t      rs2_data;
  word_t      sum;
  word_t      jump_target;
  word_t      rd_data;

  pc_stage u_pc (
    .clk(clk), .rst_n(rst_n), .halt(halt),
    .jump_taken(jump_taken), .jump_target(jump_target), .pc(pc)
  );

  decode_stage u_decode (
    .inst(inst), .rs1_addr(rs1_addr), .rs2_addr(rs2_addr), .rd_addr(rd_addr),
    .imm(imm), .a_sel(a_sel), .wb_sel(wb_sel), .funct3(funct3),
    .reg_we(reg_we), .is_load(is_load), .is_store(is_store),
    .jump_taken(jump_taken), .is_jalr(is_jalr), .halt(halt)
  );

  // writeback closes the loop here
  reg_file u_regs (
    .clk(clk), .rst_n(rst_n), .we(reg_we), .waddr(rd_addr), .wdata(rd_data),
    .raddr1(rs1_addr), .raddr2(rs2_addr), .rdata1(rs1_data), .rdata2(rs2_data)
  );

  exec_stage u_exec (
    .pc(pc), .rs1_data(rs1_data), .imm(imm), .a_sel(a_sel),
    .is_jalr(is_jalr), .sum(sum), .jump_target(jump_target)
  );

  mem_wb_stage u_mem_wb (
    .pc(pc), .sum(sum), .rs2_data(rs2_data), .funct3(funct3),
    .is_load(is_load), .is_store(is_store), .wb_sel(wb_sel),
    .mem_rdata(mem_rdata), .mem_addr(mem_addr), .mem_ren(mem_ren),
    .mem_wen(mem_wen), .mem_wdata(mem_wdata), .mem_wmask(mem_wmask),
    .rd_data(rd_data)
  );

endmodule

//--- source/rv_pkg.sv
package rv_pkg;

  localparam int xlen = 32;

  // data, address and instruction words share one width
  typedef logic [xlen-1:0] word_t;
  typedef logic [4:0]      reg_addr_t;
  typedef logic [3:0]      wmask_t;   // one bit per byte lane

  localparam word_t reset_pc = 32'h8000_0000;

  // only the opcodes this core executes
  typedef enum logic [6:0] {
    op_imm = 7'b0010011,
    auipc  = 7'b0010111,
    lui    = 7'b0110111,
    jal    = 7'b1101111,
    jalr   = 7'b1100111,
    load   = 7'b0000011,
    store  = 7'b0100011,
    system = 7'b1110011
  } opcode_e;

  // funct3 for loads and stores
  localparam logic [2:0] f3_b  = 3'b000;
  localparam logic [2:0] f3_h  = 3'b001;
  localparam logic [2:0] f3_w  = 3'b010;
  localparam logic [2:0] f3_bu = 3'b100;
  localparam logic [2:0] f3_hu = 3'b101;

  // first adder operand
  typedef enum logic {
    a_sel_rs1 = 1'b0,
    a_sel_pc  = 1'b1
  } a_sel_e;

  // writeback source
  typedef enum logic [1:0] {
    wb_sel_sum  = 2'd0,
    wb_sel_pc4  = 2'd1,
    wb_sel_load = 2'd2
  } wb_sel_e;

endpackage

//--- tb/rv_core_sva.sv
`timescale 1ns/1ps

module rv_core_sva import rv_pkg::*; (
  input logic   clk,
  input logic   rst_n,
  input word_t  pc,
  input logic   mem_ren,
  input logic   mem_wen,
  input wmask_t mem_wmask,
  input logic   halt
);

  int fail_count = 0;   // failed assertions so far

  // one memory access per cycle
  property no_read_and_write;
    @(posedge clk) disable iff (!rst_n) !(mem_ren && mem_wen);
  endproperty

  property mask_only_on_write;
    @(posedge clk) disable iff (!rst_n) (mem_wmask != 4'b0000) |-> mem_wen;
  endproperty

  property pc_word_aligned;
    @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00;
  endproperty

  // ebreak parks the pc
  property halt_holds_pc;
    @(posedge clk) disable iff (!rst_n) halt |=> $stable(pc);
  endproperty

  a_no_read_and_write: assert property (no_read_and_write)
    else begin
      $error("mem_ren and mem_wen high in the same cycle");
      fail_count++;
    end

  a_mask_only_on_write: assert property (mask_only_on_write)
    else begin
      $error("mem_wmask nonzero while mem_wen is low");
      fail_count++;
    end

  a_pc_word_aligned: assert property (pc_word_aligned)
    else begin
      $error("pc not word aligned");
      fail_count++;
    end

  a_halt_holds_pc: assert property (halt_holds_pc)
    else begin
      $error("pc moved while halt was high");
      fail_count++;
    end

endmodule

bind rv_core rv_core_sva u_sva (
  .clk(clk), .rst_n(rst_n), .pc(pc), .mem_ren(mem_ren), .mem_wen(mem_wen),
  .mem_wmask(mem_wmask), .halt(halt)
);

//--- tb/rv_core_tb.sv
`timescale 1ns/1ps

module rv_core_tb import rv_pkg::*; ();

  localparam int    max_rows     = 64;
  localparam int    reset_cycles = 5;
  localparam word_t data_base    = 32'h8000_1000;
  localparam word_t word0_init   = 32'h7f80_ff01;  // bytes 01 ff 80 7f
  localparam word_t word1_init   = 32'h1b2c_e4d5;

  logic   clk;
  logic   rst_n;
  word_t  inst;
  word_t  mem_rdata;
  word_t  pc;
  word_t  mem_addr;
  logic   mem_ren;
  logic   mem_wen;
  word_t  mem_wdata;
  wmask_t mem_wmask;
  logic   halt;

  // expectation table, one row per cycle
  word_t  row_inst  [max_rows];
  word_t  row_pc    [max_rows];
  logic   row_ren   [max_rows];
  logic   row_wen   [max_rows];
  word_t  row_addr  [max_rows];
  word_t  row_wdata [max_rows];
  wmask_t row_wmask [max_rows];
  logic   row_halt  [max_rows];
  int     n_rows;
  word_t  build_pc;          // pc expected by the next added row

  word_t  dmem [16];         // words from data_base up
  int     cycle_count = 0;
  int     cycle_limit;

  rv_core dut (
    .clk(clk), .rst_n(rst_n), .inst(inst), .mem_rdata(mem_rdata),
    .pc(pc), .mem_addr(mem_addr), .mem_ren(mem_ren), .mem_wen(mem_wen),
    .mem_wdata(mem_wdata), .mem_wmask(mem_wmask), .halt(halt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // same-cycle read, masked write at the edge
  assign mem_rdata = dmem[mem_addr[5:2]];

  always @(posedge clk) begin
    if (rst_n && mem_wen) begin
      for (int b = 0; b < 4; b++) begin
        if (mem_wmask[b]) begin
          dmem[mem_addr[5:2]][8*b +: 8] <= mem_wdata[8*b +: 8];
        end
      end
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: test did not finish within %0d cycles", cycle_limit);
      $display(">>> FAIL");
      $fatal(1, "run stopped by timeout");
    end
  end

  // small assembler for the test program
  function automatic word_t i_type(opcode_e op, logic [2:0] f3, reg_addr_t rd,
                                   reg_addr_t rs1, logic [11:0] imm);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic word_t s_type(logic [2:0] f3, reg_addr_t rs1, reg_addr_t rs2,
                                   logic [11:0] imm);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], store};
  endfunction

  function automatic word_t u_type(opcode_e op, reg_addr_t rd, logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  function automatic word_t j_type(reg_addr_t rd, logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, jal};
  endfunction

  function automatic word_t sext12(logic [11:0] v);
    return {{20{v[11]}}, v};
  endfunction

  function automatic word_t sext8(logic [7:0] v);
    return {{24{v[7]}}, v};
  endfunction

  function automatic word_t sext16(logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  function automatic logic [7:0] byte_at(word_t w, int k);
    return w[8*k +: 8];
  endfunction

  function automatic logic [15:0] half_at(word_t w, int k);
    return w[8*k +: 16];
  endfunction

  task automatic add_row(input word_t ins, input logic ren, input logic wen,
                         input word_t addr, input word_t wdata, input wmask_t wmask,
                         input logic hlt);
    row_inst[n_rows]  = ins;
    row_pc[n_rows]    = build_pc;
    row_ren[n_rows]   = ren;
    row_wen[n_rows]   = wen;
    row_addr[n_rows]  = addr;
    row_wdata[n_rows] = wdata;
    row_wmask[n_rows] = wmask;
    row_halt[n_rows]  = hlt;
    n_rows++;
    build_pc = build_pc + 32'd4;
  endtask

  task automatic add_plain(input word_t ins);
    add_row(ins, 1'b0, 1'b0, '0, '0, 4'b0000, 1'b0);
  endtask

  // sw rs2, off(x1), observed on the memory port
  task automatic sw_row(input reg_addr_t rs2, input int off, input word_t value);
    add_row(s_type(f3_w, 5'd1, rs2, 12'(off)), 1'b0, 1'b1, data_base + off, value,
            4'b1111, 1'b0);
  endtask

  task automatic load_row(input logic [2:0] f3, input int off, input reg_addr_t rd);
    add_row(i_type(load, f3, rd, 5'd1, 12'(off)), 1'b1, 1'b0,
            (data_base + off) & 32'hffff_fffc, '0, 4'b0000, 1'b0);
  endtask

  task automatic build_program();
    word_t x2v;
    word_t x4v;
    word_t x7v;
    word_t target;
    build_pc = reset_pc;
    n_rows   = 0;
    add_plain(u_type(lui, 5'd1, 20'h80001));         // x1 = data_base
    sw_row(5'd1, 32, {20'h80001, 12'h000});
    x2v = sext12(12'hffb);
    add_plain(i_type(op_imm, 3'b000, 5'd2, 5'd0, 12'hffb));
    sw_row(5'd2, 32, x2v);
    x2v = x2v + sext12(12'h123);
    add_plain(i_type(op_imm, 3'b000, 5'd2, 5'd2, 12'h123));
    sw_row(5'd2, 36, x2v);
    add_plain(u_type(auipc, 5'd3, 20'h12345));
    sw_row(5'd3, 32, build_pc - 32'd4 + {20'h12345, 12'h000});
    x4v    = build_pc + 32'd4;                      // jal link
    target = build_pc + 32'd16;
    add_plain(j_type(5'd4, 21'd16));
    build_pc = target;
    sw_row(5'd4, 32, x4v);
    // odd offset, so bit 0 of the sum must be dropped
    target = (x4v + sext12(12'h021)) & 32'hffff_fffe;
    add_plain(i_type(jalr, 3'b000, 5'd5, 5'd4, 12'h021));
    build_pc = target;
    sw_row(5'd5, 32, row_pc[n_rows-1] + 32'd4);
    for (int k = 0; k < 4; k++) begin
      load_row(f3_b, k, 5'd6);
      sw_row(5'd6, 32, sext8(byte_at(word0_init, k)));
      load_row(f3_bu, k, 5'd6);
      sw_row(5'd6, 32, {24'h000000, byte_at(word0_init, k)});
    end
    for (int k = 0; k < 4; k += 2) begin
      load_row(f3_h, k, 5'd6);
      sw_row(5'd6, 32, sext16(half_at(word0_init, k)));
      load_row(f3_hu, k, 5'd6);
      sw_row(5'd6, 32, {16'h0000, half_at(word0_init, k)});
    end
    load_row(f3_w, 0, 5'd6);
    sw_row(5'd6, 32, word0_init);
    load_row(f3_w, 4, 5'd6);
    sw_row(5'd6, 32, word1_init);
    x7v = {20'h9abce, 12'h000} + sext12(12'h5f1);
    add_plain(u_type(lui, 5'd7, 20'h9abce));
    add_plain(i_type(op_imm, 3'b000, 5'd7, 5'd7, 12'h5f1));
    for (int k = 0; k < 4; k++) begin
      add_row(s_type(f3_b, 5'd1, 5'd7, 12'(40 + k)), 1'b0, 1'b1, data_base + 32'd40,
              x7v << (8 * k), 4'b0001 << k, 1'b0);
    end
    add_row(s_type(f3_h, 5'd1, 5'd7, 12'd42), 1'b0, 1'b1, data_base + 32'd40,
            x7v << 16, 4'b1100, 1'b0);
    add_row(s_type(f3_h, 5'd1, 5'd7, 12'd40), 1'b0, 1'b1, data_base + 32'd40,
            x7v, 4'b0011, 1'b0);
    // word now holds the low half of x7 twice
    load_row(f3_w, 40, 5'd8);
    sw_row(5'd8, 32, {x7v[15:0], x7v[15:0]});
    add_plain(32'h0000_0133);                       // unknown opcode aimed at x2
    sw_row(5'd2, 36, x2v);
    for (int k = 0; k < 2; k++) begin
      add_row(32'h0010_0073, 1'b0, 1'b0, '0, '0, 4'b0000, 1'b1);
      build_pc = build_pc - 32'd4;                  // halted pc stays put
    end
  endtask

  task automatic check_value(input word_t actual, input word_t expected, input string what);
    if (actual !== expected) begin
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
      $display(">>> FAIL");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  // bound checker counts its failures
  task automatic check_assertions();
    if (dut.u_sva.fail_count != 0) begin
      $display("a bound assertion on the core ports failed");
      $display(">>> FAIL");
      $fatal(1, "stopped on assertion failure");
    end
  endtask

  task automatic check_row(input int r);
    check_assertions();
    check_value(pc, row_pc[r], $sformatf("row %0d pc", r));
    check_value(32'(mem_ren), 32'(row_ren[r]), $sformatf("row %0d mem_ren", r));
    check_value(32'(mem_wen), 32'(row_wen[r]), $sformatf("row %0d mem_wen", r));
    check_value(32'(halt), 32'(row_halt[r]), $sformatf("row %0d halt", r));
    check_value(32'(mem_wmask), 32'(row_wmask[r]), $sformatf("row %0d mem_wmask", r));
    if (row_ren[r] || row_wen[r]) begin
      check_value(mem_addr, row_addr[r], $sformatf("row %0d mem_addr", r));
    end
    if (row_wen[r]) begin
      check_value(mem_wdata, row_wdata[r], $sformatf("row %0d mem_wdata", r));
    end
  endtask

  initial begin
    rst_n = 1'b0;
    for (int i = 0; i < 16; i++) begin
      dmem[i] = 32'h5a00_00a5 ^ (32'(i) * 32'h0101_0101);
    end
    dmem[0] = word0_init;
    dmem[1] = word1_init;
    build_program();
    cycle_limit = n_rows + reset_cycles + 20;
    inst = row_inst[0];
    repeat (reset_cycles) @(posedge clk);
    #10;
    rst_n = 1'b1;
    for (int r = 0; r < n_rows; r++) begin
      inst = row_inst[r];
      #40;                                          // outputs settled mid-cycle
      check_row(r);
      @(posedge clk);
      #10;
    end
    if (dut.u_sva.fail_count != 0) begin
      $display("a bound assertion on the core ports failed");
      $display(">>> FAIL");
      $fatal(1, "stopped on assertion failure");
    end else begin
      $display(">>> PASS");
      $finish;
    end
  end

endmodule
